// ==== testbench/bpu_cases.txt ====
# name if_pc if_inst flush if_stall ex_valid ex_taken ex_pdt_true ex_pc ex_inst ex_target
#   ex_history ex_stall | exp_branch_or_not exp_pdt_res exp_pdt_pc exp_history (all hex)
nop_seq 00001000 00000013 0 0 0 0 0 00000000 00000000 00000000 0000 0 0 0 00001004 0000
jal_flush 00001000 010000ef 1 0 0 0 0 00000000 00000000 00000000 0000 0 0 0 00001004 0000
jal_stall 00001000 010000ef 0 1 0 0 0 00000000 00000000 00000000 0000 0 0 0 00001004 0000
jal_taken 00001000 010000ef 0 0 0 0 0 00000000 00000000 00000000 0000 0 1 1 00001010 0000
br_fresh 00002000 00000463 0 0 1 1 0 00002000 00000463 00002100 0000 0 1 0 00002004 0000
br_trained 00002000 00000463 0 0 0 0 0 00000000 00000000 00000000 0000 0 1 1 00002100 0001
br_true_upd 00002000 00000463 0 0 1 0 1 00002000 00000463 00000000 0000 0 1 1 00002100 0001
br_still_taken 00002000 00000463 0 0 0 0 0 00000000 00000000 00000000 0000 0 1 1 00002100 0002
jalr_miss 00003040 00028067 0 0 1 1 1 00003040 00028067 00005000 0000 0 1 0 00003044 0002
jalr_hit 00003040 00028067 0 0 0 0 0 00000000 00000000 00000000 0000 0 1 1 00005000 0005
jalr_tag_miss 00043040 00028067 0 0 0 0 0 00000000 00000000 00000000 0000 0 1 0 00043044 0005
call_p1 00004000 00000013 0 0 1 0 1 00004000 010000ef 00000000 0000 0 0 0 00004004 0005
call_p2 00004100 00000013 0 0 1 0 1 00004100 010000ef 00000000 0000 0 0 0 00004104 000a
ret_p2 00006000 00008067 0 0 1 0 1 00006000 00008067 00000000 0000 0 1 1 00004104 0014
ret_p1 00006000 00008067 0 0 0 0 0 00000000 00000000 00000000 0000 0 1 1 00004004 0028
ex_stalled 00007000 00000013 0 0 1 1 0 00007008 00000463 00007100 0000 1 0 0 00007004 0028
stall_no_effect 00007008 00000463 0 0 0 0 0 00000000 00000000 00000000 0000 0 1 0 0000700c 0028
flush_load 00008000 00000013 1 0 0 0 0 00000000 00000000 00000000 abcd 0 0 0 00008004 0028
hist_loaded 00008000 00000013 0 0 0 0 0 00000000 00000000 00000000 0000 0 0 0 00008004 abcd
ret_empty 00009000 00000013 0 0 1 0 1 00006000 00008067 00000000 0000 0 0 0 00009004 abcd
call_1 00009000 00000013 0 0 1 0 1 0000c000 010000ef 00000000 0000 0 0 0 00009004 579a
call_2 00009000 00000013 0 0 1 0 1 0000c010 010000ef 00000000 0000 0 0 0 00009004 af34
call_3 00009000 00000013 0 0 1 0 1 0000c020 010000ef 00000000 0000 0 0 0 00009004 5e68
call_4 00009000 00000013 0 0 1 0 1 0000c030 010000ef 00000000 0000 0 0 0 00009004 bcd0
call_5 00009000 00000013 0 0 1 0 1 0000c040 010000ef 00000000 0000 0 0 0 00009004 79a0
call_6 00009000 00000013 0 0 1 0 1 0000c050 010000ef 00000000 0000 0 0 0 00009004 f340
call_7 00009000 00000013 0 0 1 0 1 0000c060 010000ef 00000000 0000 0 0 0 00009004 e680
call_8 00009000 00000013 0 0 1 0 1 0000c070 010000ef 00000000 0000 0 0 0 00009004 cd00
call_9 00009000 00000013 0 0 1 0 1 0000c080 010000ef 00000000 0000 0 0 0 00009004 9a00
ret_wrapped 00006000 00008067 0 0 0 0 0 00000000 00000000 00000000 0000 0 1 1 0000c084 3400

// ==== list.f ====
+incdir+include
design/rv_isa_pkg.sv
design/bpu_state_pkg.sv
design/direction_predictor.sv
design/target_buffer.sv
design/return_stack.sv
design/predict_select.sv
design/bpu_top.sv
testbench/tb_clock_gen.sv
testbench/bpu_assertions.sv
testbench/bpu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the branch predictor testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module bpu_tb \
    -f list.f \
    -o bpu_sim

./obj_dir/bpu_sim | tee sim.log || true

if grep -q "TEST PASS" sim.log; then
    exit 0
fi
exit 1

// ==== testbench/bpu_tb.sv ====
`default_nettype none

`include "bpu_consts.svh"

module bpu_tb;

    localparam int MAX_LINES = 200;
    localparam int FIELDS = 17;

    logic        clk;
    logic        rst;
    logic [31:0] if_pc;
    logic [31:0] if_inst;
    logic        if_stall;
    logic        flush;
    logic        ex_valid;
    logic        ex_taken;
    logic        ex_pdt_true;
    logic [31:0] ex_pc;
    logic [31:0] ex_inst;
    logic [31:0] ex_target;
    logic [15:0] ex_history;
    logic        ex_stall;
    logic        branch_or_not;
    logic [31:0] pdt_pc;
    logic        pdt_res;
    logic [15:0] history;

    // one record of the cases file
    string       name;
    string       line;
    logic [31:0] f [FIELDS-1];
    int          fd;
    int          n_fields;
    int          n_lines;
    int          n_records;

    tb_clock_gen u_clk (
        .clk_o (clk)
    );

    bpu_top u_dut (
        .clk               (clk),
        .rst               (rst),
        .if_pc_i           (if_pc),
        .if_inst_i         (if_inst),
        .if_stall_i        (if_stall),
        .flush_i           (flush),
        .ex_branch_valid_i (ex_valid),
        .ex_branch_taken_i (ex_taken),
        .ex_pdt_true_i     (ex_pdt_true),
        .ex_pc_i           (ex_pc),
        .ex_inst_i         (ex_inst),
        .ex_target_i       (ex_target),
        .ex_history_i      (ex_history),
        .ex_stall_i        (ex_stall),
        .branch_or_not_o   (branch_or_not),
        .pdt_pc_o          (pdt_pc),
        .pdt_res_o         (pdt_res),
        .history_o         (history)
    );

    task automatic compare_value(input string test, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s %s expected %h actual %h", test, what, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "run aborted");
    endtask

    initial begin
        rst = 1'b1;
        if_pc = '0;
        if_inst = '0;
        if_stall = 1'b0;
        flush = 1'b0;
        ex_valid = 1'b0;
        ex_taken = 1'b0;
        ex_pdt_true = 1'b0;
        ex_pc = '0;
        ex_inst = '0;
        ex_target = '0;
        ex_history = '0;
        ex_stall = 1'b0;
        n_lines = 0;
        n_records = 0;

        fd = $fopen("testbench/bpu_cases.txt", "r");
        if (fd == 0) begin
            abort_run("could not open testbench/bpu_cases.txt");
        end

        repeat (10) @(posedge clk);
        #1 rst = 1'b0;

        while (!$feof(fd) && n_lines < MAX_LINES) begin
            n_lines++;
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            n_fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                f[10], f[11], f[12], f[13], f[14], f[15]);
            if (n_fields != FIELDS) begin
                abort_run($sformatf("record on line %0d has too few fields", n_lines));
            end
            // drive shortly after the edge, check just before the next one
            @(posedge clk);
            #1;
            if_pc = f[0];
            if_inst = f[1];
            flush = f[2][0];
            if_stall = f[3][0];
            ex_valid = f[4][0];
            ex_taken = f[5][0];
            ex_pdt_true = f[6][0];
            ex_pc = f[7];
            ex_inst = f[8];
            ex_target = f[9];
            ex_history = f[10][15:0];
            ex_stall = f[11][0];
            #2;
            compare_value(name, "branch_or_not", f[12], {31'b0, branch_or_not});
            compare_value(name, "pdt_res", f[13], {31'b0, pdt_res});
            compare_value(name, "pdt_pc", f[14], pdt_pc);
            compare_value(name, "history", f[15], {16'b0, history});
            n_records++;
        end
        $fclose(fd);

        if (n_lines >= MAX_LINES) begin
            abort_run("cases file exceeds the line limit");
        end
        if (n_records > 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            abort_run("no records were read from the cases file");
        end
    end

endmodule

`default_nettype wire

// ==== testbench/bpu_assertions.sv ====
`default_nettype none

`include "bpu_consts.svh"

module bpu_assertions
    import bpu_state_pkg::*;
(
    input wire logic                 clk,
    input wire logic                 rst,
    input wire logic                 flush_i,
    input wire logic                 branch_or_not_o,
    input wire logic                 pdt_res_o,
    input wire logic [`BPU_XLEN-1:0] pdt_pc_o,
    input wire history_t             history_o
);

    // a taken prediction is always for a control transfer
    a_res_needs_cti: assert property (@(posedge clk) pdt_res_o |-> branch_or_not_o)
        else $error("pdt_res_o high without branch_or_not_o");

    a_flush_idle: assert property (@(posedge clk) flush_i |-> !branch_or_not_o)
        else $error("branch_or_not_o high during flush");

    // predicted pc stays halfword aligned
    a_pc_aligned: assert property (@(posedge clk) pdt_pc_o[0] == 1'b0)
        else $error("pdt_pc_o is odd");

    a_hist_reset: assert property (@(posedge clk) $past(rst) |-> history_o == '0)
        else $error("history not cleared by reset");

endmodule

bind bpu_top bpu_assertions u_assert (
    .clk             (clk),
    .rst             (rst),
    .flush_i         (flush_i),
    .branch_or_not_o (branch_or_not_o),
    .pdt_res_o       (pdt_res_o),
    .pdt_pc_o        (pdt_pc_o),
    .history_o       (history_o)
);

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD = 2
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

// ==== design/bpu_top.sv ====
`default_nettype none

`include "bpu_consts.svh"

module bpu_top
    import bpu_state_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`BPU_XLEN-1:0] if_pc_i,
    input  logic [`BPU_XLEN-1:0] if_inst_i,
    input  logic                 if_stall_i,
    input  logic                 flush_i,
    input  logic                 ex_branch_valid_i,
    input  logic                 ex_branch_taken_i,
    input  logic                 ex_pdt_true_i,
    input  logic [`BPU_XLEN-1:0] ex_pc_i,
    input  logic [`BPU_XLEN-1:0] ex_inst_i,
    input  logic [`BPU_XLEN-1:0] ex_target_i,
    input  history_t             ex_history_i,
    input  logic                 ex_stall_i,
    output logic                 branch_or_not_o,
    output logic [`BPU_XLEN-1:0] pdt_pc_o,
    output logic                 pdt_res_o,
    output history_t             history_o
);

    logic                 upd_en;
    logic                 dir_taken;
    logic                 btb_hit;
    logic [`BPU_XLEN-1:0] btb_target;
    logic                 ras_valid;
    logic [`BPU_XLEN-1:0] ras_top;

    direction_predictor u_dir (
        .clk               (clk),
        .rst               (rst),
        .flush_i           (flush_i),
        .upd_en_i          (upd_en),
        .if_pc_i           (if_pc_i),
        .ex_pc_i           (ex_pc_i),
        .ex_branch_taken_i (ex_branch_taken_i),
        .ex_pdt_true_i     (ex_pdt_true_i),
        .ex_history_i      (ex_history_i),
        .dir_taken_o       (dir_taken),
        .history_o         (history_o)
    );

    target_buffer u_btb (
        .clk               (clk),
        .rst               (rst),
        .upd_en_i          (upd_en),
        .if_pc_i           (if_pc_i),
        .ex_pc_i           (ex_pc_i),
        .ex_inst_i         (ex_inst_i),
        .ex_branch_taken_i (ex_branch_taken_i),
        .ex_target_i       (ex_target_i),
        .btb_hit_o         (btb_hit),
        .btb_target_o      (btb_target)
    );

    return_stack u_ras (
        .clk         (clk),
        .rst         (rst),
        .upd_en_i    (upd_en),
        .ex_pc_i     (ex_pc_i),
        .ex_inst_i   (ex_inst_i),
        .ras_valid_o (ras_valid),
        .ras_top_o   (ras_top)
    );

    predict_select u_sel (
        .flush_i           (flush_i),
        .if_stall_i        (if_stall_i),
        .ex_branch_valid_i (ex_branch_valid_i),
        .ex_stall_i        (ex_stall_i),
        .if_pc_i           (if_pc_i),
        .if_inst_i         (if_inst_i),
        .dir_taken_i       (dir_taken),
        .btb_hit_i         (btb_hit),
        .btb_target_i      (btb_target),
        .ras_valid_i       (ras_valid),
        .ras_top_i         (ras_top),
        .upd_en_o          (upd_en),
        .branch_or_not_o   (branch_or_not_o),
        .pdt_pc_o          (pdt_pc_o),
        .pdt_res_o         (pdt_res_o)
    );

endmodule

`default_nettype wire

// ==== design/predict_select.sv ====
`default_nettype none

`include "bpu_consts.svh"

module predict_select
    import rv_isa_pkg::*;
(
    input  logic                 flush_i,
    input  logic                 if_stall_i,
    input  logic                 ex_branch_valid_i,
    input  logic                 ex_stall_i,
    input  logic [`BPU_XLEN-1:0] if_pc_i,
    input  logic [`BPU_XLEN-1:0] if_inst_i,
    input  logic                 dir_taken_i,
    input  logic                 btb_hit_i,
    input  logic [`BPU_XLEN-1:0] btb_target_i,
    input  logic                 ras_valid_i,
    input  logic [`BPU_XLEN-1:0] ras_top_i,
    output logic                 upd_en_o,
    output logic                 branch_or_not_o,
    output logic [`BPU_XLEN-1:0] pdt_pc_o,
    output logic                 pdt_res_o
);

    cti_kind_e            if_kind;
    logic                 if_jal;
    logic [`BPU_XLEN-1:0] seq_pc;

    // the one place where execute feedback is accepted
    assign upd_en_o = ex_branch_valid_i && !flush_i && !if_stall_i && !ex_stall_i;

    assign if_kind = cti_kind(if_inst_i);
    assign if_jal = is_jal(if_inst_i);
    assign seq_pc = if_pc_i + `BPU_XLEN'd4;

    always_comb begin
        branch_or_not_o = 1'b0;
        pdt_res_o = 1'b0;
        pdt_pc_o = seq_pc;
        // flush and fetch stall both give the idle prediction
        if (!flush_i && !if_stall_i && if_kind != CTI_NONE) begin
            branch_or_not_o = 1'b1;
            if (if_kind == CTI_RET) begin
                // stack first, btb as fallback
                if (ras_valid_i) begin
                    pdt_res_o = 1'b1;
                    pdt_pc_o = ras_top_i;
                end else if (btb_hit_i) begin
                    pdt_res_o = 1'b1;
                    pdt_pc_o = btb_target_i;
                end
            end else if (!if_jal && if_kind != CTI_BRANCH) begin
                // indirect jump, only the btb knows the target
                pdt_res_o = btb_hit_i;
                if (btb_hit_i) begin
                    pdt_pc_o = btb_target_i;
                end
            end else if (if_jal) begin
                pdt_res_o = 1'b1;
                pdt_pc_o = if_pc_i + j_offset(if_inst_i);
            end else begin
                pdt_res_o = dir_taken_i;
                if (dir_taken_i) begin
                    pdt_pc_o = btb_hit_i ? btb_target_i : if_pc_i + b_offset(if_inst_i);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/return_stack.sv ====
`default_nettype none

`include "bpu_consts.svh"

module return_stack
    import rv_isa_pkg::*;
    import bpu_state_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 upd_en_i,
    input  logic [`BPU_XLEN-1:0] ex_pc_i,
    input  logic [`BPU_XLEN-1:0] ex_inst_i,
    output logic                 ras_valid_o,
    output logic [`BPU_XLEN-1:0] ras_top_o
);

    localparam int IDX_W = $clog2(`BPU_RAS_DEPTH);
    localparam ras_ptr_t RAS_FULL = ras_ptr_t'(`BPU_RAS_DEPTH);

    logic [`BPU_XLEN-1:0] stack_q [`BPU_RAS_DEPTH];
    ras_ptr_t             depth_q;
    ras_ptr_t             top_ptr;
    cti_kind_e            ex_kind;
    logic                 push;
    logic                 pop;
    logic                 full;
    logic [IDX_W-1:0]     wr_idx;

    assign ex_kind = cti_kind(ex_inst_i);
    assign full = (depth_q == RAS_FULL);
    assign push = upd_en_i && (ex_kind == CTI_CALL);
    assign pop = upd_en_i && (ex_kind == CTI_RET) && (depth_q != '0);

    // a full depth has zero index bits, so overflow wraps to the bottom entry
    assign wr_idx = depth_q[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            depth_q <= '0;
        end else if (push) begin
            depth_q <= full ? ras_ptr_t'(1) : depth_q + 1'b1;
        end else if (pop) begin
            depth_q <= depth_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            stack_q[wr_idx] <= ex_pc_i + `BPU_XLEN'd4;
        end
    end

    assign top_ptr = depth_q - 1'b1;
    assign ras_top_o = stack_q[top_ptr[IDX_W-1:0]];
    assign ras_valid_o = (depth_q != '0);

endmodule

`default_nettype wire

// ==== design/target_buffer.sv ====
`default_nettype none

`include "bpu_consts.svh"

module target_buffer
    import rv_isa_pkg::*;
    import bpu_state_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 upd_en_i,
    input  logic [`BPU_XLEN-1:0] if_pc_i,
    input  logic [`BPU_XLEN-1:0] ex_pc_i,
    input  logic [`BPU_XLEN-1:0] ex_inst_i,
    input  logic                 ex_branch_taken_i,
    input  logic [`BPU_XLEN-1:0] ex_target_i,
    output logic                 btb_hit_o,
    output logic [`BPU_XLEN-1:0] btb_target_o
);

    localparam int IDX_W = `BPU_BTB_IDX_HI - `BPU_BTB_IDX_LO + 1;

    logic [`BPU_BTB_ENTRIES-1:0] valid_q;
    btb_tag_t                    tag_q [`BPU_BTB_ENTRIES];
    logic [`BPU_XLEN-1:0]        target_q [`BPU_BTB_ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    btb_tag_t         rd_tag;
    btb_tag_t         wr_tag;
    logic             alloc;

    assign rd_idx = if_pc_i[`BPU_BTB_IDX_HI:`BPU_BTB_IDX_LO];
    assign wr_idx = ex_pc_i[`BPU_BTB_IDX_HI:`BPU_BTB_IDX_LO];
    assign rd_tag = if_pc_i[`BPU_XLEN-1 -: `BPU_BTB_TAG_WIDTH];
    assign wr_tag = ex_pc_i[`BPU_XLEN-1 -: `BPU_BTB_TAG_WIDTH];

    assign btb_hit_o = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign btb_target_o = target_q[rd_idx];

    // any taken branch, jal or jalr claims its slot
    assign alloc = upd_en_i && ex_branch_taken_i && (cti_kind(ex_inst_i) != CTI_NONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (alloc) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            tag_q[wr_idx] <= wr_tag;
            target_q[wr_idx] <= ex_target_i;
        end
    end

endmodule

`default_nettype wire

// ==== design/direction_predictor.sv ====
`default_nettype none

`include "bpu_consts.svh"

module direction_predictor
    import bpu_state_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush_i,
    input  logic                 upd_en_i,
    input  logic [`BPU_XLEN-1:0] if_pc_i,
    input  logic [`BPU_XLEN-1:0] ex_pc_i,
    input  logic                 ex_branch_taken_i,
    input  logic                 ex_pdt_true_i,
    input  history_t             ex_history_i,
    output logic                 dir_taken_o,
    output history_t             history_o
);

    sat_ctr_t bim_tbl [`BPU_BIMODAL_ENTRIES];
    history_t hist_q;
    sat_ctr_t upd_ctr;
    sat_ctr_t upd_ctr_next;

    logic [`BPU_BIM_IDX_HI-`BPU_BIM_IDX_LO:0] rd_idx;
    logic [`BPU_BIM_IDX_HI-`BPU_BIM_IDX_LO:0] wr_idx;

    assign rd_idx = if_pc_i[`BPU_BIM_IDX_HI:`BPU_BIM_IDX_LO];
    assign wr_idx = ex_pc_i[`BPU_BIM_IDX_HI:`BPU_BIM_IDX_LO];

    assign dir_taken_o = bim_tbl[rd_idx][1];
    assign upd_ctr = bim_tbl[wr_idx];

    // one saturating step toward the resolved outcome
    always_comb begin
        upd_ctr_next = upd_ctr;
        if (ex_branch_taken_i && upd_ctr != SAT_CTR_MAX) begin
            upd_ctr_next = upd_ctr + 2'd1;
        end else if (!ex_branch_taken_i && upd_ctr != SAT_CTR_MIN) begin
            upd_ctr_next = upd_ctr - 2'd1;
        end
    end

    // trained only on mispredictions
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `BPU_BIMODAL_ENTRIES; i++) begin
                bim_tbl[i] <= SAT_CTR_INIT;
            end
        end else if (upd_en_i && !ex_pdt_true_i) begin
            bim_tbl[wr_idx] <= upd_ctr_next;
        end
    end

    // flush reloads the pipeline's copy of the history
    always_ff @(posedge clk) begin
        if (rst) begin
            hist_q <= '0;
        end else if (flush_i) begin
            hist_q <= ex_history_i;
        end else if (upd_en_i) begin
            hist_q <= {hist_q[`BPU_HIST_WIDTH-2:0], ex_branch_taken_i};
        end
    end

    assign history_o = hist_q;

endmodule

`default_nettype wire

// ==== design/bpu_state_pkg.sv ====
`default_nettype none

`include "bpu_consts.svh"

package bpu_state_pkg;

    typedef logic [`BPU_HIST_WIDTH-1:0] history_t;

    // bit 1 is the taken prediction
    typedef logic [1:0] sat_ctr_t;
    localparam sat_ctr_t SAT_CTR_INIT = 2'b01;
    localparam sat_ctr_t SAT_CTR_MAX = 2'b11;
    localparam sat_ctr_t SAT_CTR_MIN = 2'b00;

    typedef logic [`BPU_BTB_TAG_WIDTH-1:0] btb_tag_t;

    // counts 0 .. depth, so one bit wider than the entry index
    typedef logic [$clog2(`BPU_RAS_DEPTH+1)-1:0] ras_ptr_t;

endpackage

`default_nettype wire

// ==== design/rv_isa_pkg.sv ====
`default_nettype none

`include "bpu_consts.svh"

package rv_isa_pkg;

    // B-format field layout
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } rv_btype_t;

    // J-format field layout
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_jtype_t;

    typedef union packed {
        rv_btype_t b;
        rv_jtype_t j;
    } rv_inst_u;

    typedef enum logic [2:0] {
        CTI_NONE,
        CTI_BRANCH,
        CTI_JAL,
        CTI_JALR,
        CTI_CALL,
        CTI_RET
    } cti_kind_e;

    // jal always counts as a call, plain jalr only without a link register
    function automatic cti_kind_e cti_kind(input logic [`BPU_XLEN-1:0] word);
        rv_inst_u  inst;
        cti_kind_e kind;
        inst = word;
        case (inst.b.opcode)
            `BPU_OP_BRANCH: kind = CTI_BRANCH;
            `BPU_OP_JAL:    kind = CTI_CALL;
            `BPU_OP_JALR: begin
                if (inst.j.rd == 5'd0 && inst.b.rs1 == `BPU_REG_RA) begin
                    kind = CTI_RET;
                end else if (inst.j.rd != 5'd0) begin
                    kind = CTI_CALL;
                end else begin
                    kind = CTI_JALR;
                end
            end
            default: kind = CTI_NONE;
        endcase
        return kind;
    endfunction

    function automatic logic is_jal(input logic [`BPU_XLEN-1:0] word);
        rv_inst_u inst;
        inst = word;
        return inst.j.opcode == `BPU_OP_JAL;
    endfunction

    function automatic logic [`BPU_XLEN-1:0] b_offset(input logic [`BPU_XLEN-1:0] word);
        rv_inst_u inst;
        inst = word;
        return {{(`BPU_XLEN-12){inst.b.imm12}}, inst.b.imm11, inst.b.imm10_5,
                inst.b.imm4_1, 1'b0};
    endfunction

    function automatic logic [`BPU_XLEN-1:0] j_offset(input logic [`BPU_XLEN-1:0] word);
        rv_inst_u inst;
        inst = word;
        return {{(`BPU_XLEN-20){inst.j.imm20}}, inst.j.imm19_12, inst.j.imm11,
                inst.j.imm10_1, 1'b0};
    endfunction

endpackage

`default_nettype wire

// ==== include/bpu_consts.svh ====
`ifndef BPU_CONSTS_SVH
`define BPU_CONSTS_SVH

// address and instruction width
`define BPU_XLEN 32

// global history length
`define BPU_HIST_WIDTH 16

// bimodal table, indexed by pc[9:1]
`define BPU_BIMODAL_ENTRIES 512
`define BPU_BIM_IDX_HI 9
`define BPU_BIM_IDX_LO 1

// direct-mapped btb, indexed by pc[9:2], tagged by pc[31:18]
`define BPU_BTB_ENTRIES 256
`define BPU_BTB_IDX_HI 9
`define BPU_BTB_IDX_LO 2
`define BPU_BTB_TAG_WIDTH 14

`define BPU_RAS_DEPTH 8

// rv32i opcodes of control transfers
`define BPU_OP_BRANCH 7'b1100011
`define BPU_OP_JAL 7'b1101111
`define BPU_OP_JALR 7'b1100111
`define BPU_REG_RA 5'd1

`endif
